// File: rtl/spi_memory_pkg.sv
// frame layout is fixed at 8 command + 16 address + 32 data bits; the memory uses only 9 address bits
package spi_memory_pkg;

	// spi frame fields, sent MSB first
	localparam int command_width = 8;
	localparam int address_width = 16;
	localparam int data_width = 32;

	// command and address come first, data word last
	localparam int frame_bits = command_width + address_width + data_width;

	// word memory
	localparam int memory_depth = 512;
	localparam int memory_address_width = $clog2(memory_depth);

	// commands
	localparam logic [command_width-1:0] opcode_write = 8'h01;
	// read only returns the addressed word on miso, which every frame does anyway
	localparam logic [command_width-1:0] opcode_read = 8'h02;

	// word repeated on the lemo pin
	localparam int serial_word_width = 8;

endpackage

// File: rtl/word_memory.sv
// simple dual-port block RAM, read-before-write on a shared address, contents cleared only at power up
`timescale 1ns/1ps

module word_memory (
	input  logic clock50,
	input  logic write_enable,
	input  logic [spi_memory_pkg::memory_address_width-1:0] write_address,
	input  logic [spi_memory_pkg::data_width-1:0] write_data,
	input  logic [spi_memory_pkg::memory_address_width-1:0] read_address,
	output logic [spi_memory_pkg::data_width-1:0] read_data
);
	import spi_memory_pkg::*;

	logic [data_width-1:0] memory [memory_depth];

	// block RAM init value
	initial begin
		for (int i = 0; i < memory_depth; i++) begin
			memory[i] = '0;
		end
	end

	always_ff @(posedge clock50) begin
		if (write_enable) begin
			memory[write_address] <= write_data;
		end
	end

	// registered read, returns the old word when a write hits the same address
	always_ff @(posedge clock50) begin
		read_data <= memory[read_address];
	end

endmodule

// File: rtl/word_serializer.sv
// repeats the 8-bit word MSB first at one bit per clock; a new word is taken only at the 8-clock wrap
`timescale 1ns/1ps

module word_serializer (
	input  logic clock50,
	input  logic reset1,
	input  logic [spi_memory_pkg::serial_word_width-1:0] serial_word,
	output logic lemo
);
	import spi_memory_pkg::*;

	logic [$clog2(serial_word_width)-1:0] bit_counter;
	logic [serial_word_width-1:0] shift_word;

	always_ff @(posedge clock50) begin
		if (reset1) begin
			bit_counter <= '0;
		end else begin
			bit_counter <= bit_counter + 1'b1;
		end
	end

	// reload on the last bit of the word, shift otherwise
	always_ff @(posedge clock50) begin
		if (reset1) begin
			shift_word <= '0;
		end else if (bit_counter == serial_word_width - 1) begin
			shift_word <= serial_word;
		end else begin
			shift_word <= {shift_word[serial_word_width-2:0], 1'b0};
		end
	end

	assign lemo = shift_word[serial_word_width-1];

endmodule

// File: rtl/spi_frame_receiver.sv
// spi mode 0 slave; sclk must be at most clock50/8 and a frame must be exactly 56 bits or it is dropped
`timescale 1ns/1ps

module spi_frame_receiver (
	input  logic clock50,
	input  logic reset1,
	input  logic sclk,
	input  logic mosi,
	input  logic ssel,
	output logic miso,
	input  logic [spi_memory_pkg::data_width-1:0] read_data,
	output logic [spi_memory_pkg::command_width-1:0] command,
	output logic [spi_memory_pkg::address_width-1:0] address,
	output logic [spi_memory_pkg::data_width-1:0] data,
	output logic transaction_valid
);
	import spi_memory_pkg::*;

	// pin synchronizers, newest sample in bit 0
	logic [2:0] sclk_sync;
	logic [2:0] ssel_sync;
	logic [1:0] mosi_sync;

	logic sclk_rise;
	logic sclk_fall;
	logic selected;
	logic frame_end;

	// one spare bit so frames longer than frame_bits never alias back to it
	logic [$clog2(frame_bits + 1):0] bit_count;

	logic [data_width-1:0] frame_shift;
	logic [data_width-1:0] miso_shift;

	always_ff @(posedge clock50) begin
		if (reset1) begin
			sclk_sync <= '0;
			ssel_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			ssel_sync <= {ssel_sync[1:0], ssel};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign selected = ~ssel_sync[1];
	// chip select released
	assign frame_end = ssel_sync[1] & ~ssel_sync[2];

	// count sampled bits, saturating
	always_ff @(posedge clock50) begin
		if (reset1 || !selected) begin
			bit_count <= '0;
		end else if (sclk_rise && bit_count != '1) begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// mosi is sampled on the rising edge in mode 0
	always_ff @(posedge clock50) begin
		if (selected && sclk_rise) begin
			frame_shift <= {frame_shift[data_width-2:0], mosi_sync[1]};
		end
	end

	// after the last data bit the low word of the shift register is the data field
	assign data = frame_shift;

	// command and address become valid with the 24th bit
	always_ff @(posedge clock50) begin
		if (reset1) begin
			command <= '0;
			address <= '0;
		end else if (selected && sclk_rise
				&& bit_count == command_width + address_width - 1) begin
			{command, address} <= {frame_shift[command_width+address_width-2:0], mosi_sync[1]};
		end
	end

	// readback changes on falling edges so the host can sample on the next rising edge
	always_ff @(posedge clock50) begin
		if (reset1 || !selected) begin
			miso_shift <= '0;
		end else if (sclk_fall) begin
			if (bit_count == command_width + address_width) begin
				// first data-phase bit, memory word has settled by now
				miso_shift <= read_data;
			end else if (bit_count > command_width + address_width) begin
				miso_shift <= {miso_shift[data_width-2:0], 1'b0};
			end
		end
	end

	assign miso = miso_shift[data_width-1];

	// one strobe per complete frame, seen three clocks after ssel rises at the pin
	always_ff @(posedge clock50) begin
		if (reset1) begin
			transaction_valid <= 1'b0;
		end else begin
			transaction_valid <= frame_end && bit_count == frame_bits;
		end
	end

endmodule

// File: rtl/memory_access_control.sv
// only the low 9 address bits reach the memory; commands other than write change nothing
`timescale 1ns/1ps

module memory_access_control (
	input  logic clock50,
	input  logic reset1,
	input  logic [spi_memory_pkg::command_width-1:0] command,
	input  logic [spi_memory_pkg::address_width-1:0] address,
	input  logic [spi_memory_pkg::data_width-1:0] data,
	input  logic transaction_valid,
	output logic [spi_memory_pkg::data_width-1:0] read_data,
	output logic [7:0] leds,
	output logic [spi_memory_pkg::serial_word_width-1:0] serial_word
);
	import spi_memory_pkg::*;

	logic [memory_address_width-1:0] word_address;
	logic write_enable;

	// upper address bits alias onto the same word
	assign word_address = address[memory_address_width-1:0];

	// strobe is a single cycle, so at most one write per frame
	assign write_enable = transaction_valid && (command == opcode_write);

	// same address for write and readback, read is registered
	word_memory u_memory (
		.clock50(clock50),
		.write_enable(write_enable),
		.write_address(word_address),
		.write_data(data),
		.read_address(word_address),
		.read_data(read_data)
	);

	// leds follow the low byte of the last written word
	always_ff @(posedge clock50) begin
		if (reset1) begin
			leds <= '0;
		end else if (write_enable) begin
			leds <= data[7:0];
		end
	end

	// low byte of the addressed word, for the serial pin
	// two clocks behind an address change, one of them inside the memory
	always_ff @(posedge clock50) begin
		if (reset1) begin
			serial_word <= '0;
		end else begin
			serial_word <= read_data[serial_word_width-1:0];
		end
	end

endmodule

// File: rtl/spi_pollable_memory.sv
// spi-polled 512x32 memory on clock50; reset1 is external and sclk must not exceed clock50/8
`timescale 1ns/1ps

module spi_pollable_memory (
	input  logic clock50,
	input  logic reset1,
	input  logic sclk,
	input  logic mosi,
	input  logic ssel,
	output logic miso,
	output logic lemo,
	output logic [7:0] leds
);
	import spi_memory_pkg::*;

	logic [command_width-1:0] command;
	logic [address_width-1:0] address;
	logic [data_width-1:0] data;
	logic transaction_valid;
	logic [data_width-1:0] read_data;
	logic [serial_word_width-1:0] serial_word;

	spi_frame_receiver u_receiver (
		.clock50(clock50),
		.reset1(reset1),
		.sclk(sclk),
		.mosi(mosi),
		.ssel(ssel),
		.miso(miso),
		.read_data(read_data),
		.command(command),
		.address(address),
		.data(data),
		.transaction_valid(transaction_valid)
	);

	// memory, leds and the serial byte
	memory_access_control u_access_control (
		.clock50(clock50),
		.reset1(reset1),
		.command(command),
		.address(address),
		.data(data),
		.transaction_valid(transaction_valid),
		.read_data(read_data),
		.leds(leds),
		.serial_word(serial_word)
	);

	// fabric shift register in place of the serializer primitive
	word_serializer u_serializer (
		.clock50(clock50),
		.reset1(reset1),
		.serial_word(serial_word),
		.lemo(lemo)
	);

endmodule

// File: testbench/spi_pollable_memory_sva.sv
// bound into spi_pollable_memory; expects reset1 high from time zero and one write per frame at most
`timescale 1ns/1ps

module spi_pollable_memory_sva (
	input  logic clock50,
	input  logic reset1,
	input  logic miso,
	input  logic [7:0] leds,
	input  logic [spi_memory_pkg::command_width-1:0] command,
	input  logic [spi_memory_pkg::data_width-1:0] data,
	input  logic transaction_valid
);
	import spi_memory_pkg::*;

	int failure_count = 0;
	logic write_strobe;

	assign write_strobe = transaction_valid && (command == opcode_write);

	// strobe is a pulse, never a level
	strobe_single_cycle: assert property (@(posedge clock50) disable iff (reset1)
		transaction_valid |=> !transaction_valid)
	else begin
		$error("transaction_valid stayed high for more than one cycle");
		failure_count++;
	end

	// low data byte shows on the leds one clock after the write strobe
	leds_follow_write: assert property (@(posedge clock50) disable iff (reset1)
		write_strobe |=> leds == $past(data[7:0]))
	else begin
		$error("leds do not match the low byte of the written data");
		failure_count++;
	end

	leds_hold: assert property (@(posedge clock50) disable iff (reset1)
		!write_strobe |=> $stable(leds))
	else begin
		$error("leds changed without a write");
		failure_count++;
	end

	// outputs cleared by reset
	reset_clears_outputs: assert property (@(posedge clock50)
		reset1 |=> (miso == 1'b0 && leds == 8'h00))
	else begin
		$error("miso or leds not zero after reset");
		failure_count++;
	end

endmodule

bind spi_pollable_memory spi_pollable_memory_sva sva_checks (
	.clock50(clock50),
	.reset1(reset1),
	.miso(miso),
	.leds(leds),
	.command(command),
	.data(data),
	.transaction_valid(transaction_valid)
);

// File: testbench/tb_spi_pollable_memory.sv
// spi host at clock50/8, mode 0; only addresses written earlier in the run are ever read back
`timescale 1ns/1ps

module tb_spi_pollable_memory;
	import spi_memory_pkg::*;

	logic clock50;
	logic reset1;
	logic sclk;
	logic mosi;
	logic ssel;
	wire miso;
	wire lemo;
	wire [7:0] leds;

	int error_count;
	int errors_at_start;
	int tests_passed;
	int tests_failed;
	string test_name;

	logic [address_width-1:0] addr;
	logic [data_width-1:0] wdata;
	logic [data_width-1:0] readback;
	logic [address_width-1:0] addr_list [8];
	logic [data_width-1:0] data_list [8];
	logic [7:0] leds_before;
	logic [15:0] samples;
	logic short_seen;

	spi_pollable_memory UUT (
		.clock50(clock50),
		.reset1(reset1),
		.sclk(sclk),
		.mosi(mosi),
		.ssel(ssel),
		.miso(miso),
		.lemo(lemo),
		.leds(leds)
	);

	initial begin
		clock50 = 1'b0;
		forever #2 clock50 = ~clock50;
	end

	// poll for the frame strobe for up to 12 clocks
	task automatic wait_for_strobe(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < 12) begin
			@(negedge clock50);
			seen = UUT.transaction_valid;
			cycles++;
		end
	endtask

	// four clock50 cycles per sclk half period; miso read as sclk rises
	task automatic send_frame(input logic [command_width-1:0] cmd,
			input logic [address_width-1:0] frame_addr,
			input logic [data_width-1:0] frame_data, input int bit_total,
			output logic [data_width-1:0] word_out, output logic seen);
		logic [frame_bits-1:0] frame;
		frame = {cmd, frame_addr, frame_data};
		word_out = '0;
		@(negedge clock50);
		ssel = 1'b0;
		repeat (4) @(negedge clock50);
		for (int i = 0; i < bit_total; i++) begin
			mosi = frame[frame_bits-1-i];
			repeat (4) @(negedge clock50);
			sclk = 1'b1;
			if (i >= command_width + address_width) begin
				word_out = {word_out[data_width-2:0], miso};
			end
			repeat (4) @(negedge clock50);
			sclk = 1'b0;
		end
		repeat (4) @(negedge clock50);
		ssel = 1'b1;
		mosi = 1'b0;
		wait_for_strobe(seen);
		repeat (4) @(negedge clock50);
	endtask

	task automatic full_frame(input logic [command_width-1:0] cmd,
			input logic [address_width-1:0] frame_addr,
			input logic [data_width-1:0] frame_data, output logic [data_width-1:0] word_out);
		logic seen;
		send_frame(cmd, frame_addr, frame_data, frame_bits, word_out, seen);
		assert (seen) else begin
			$display("%s: no transaction strobe after a complete frame", test_name);
			error_count++;
		end
	endtask

	task automatic check_word(input logic [data_width-1:0] expected,
			input logic [data_width-1:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
			error_count++;
		end
	endtask

	// 16-sample window of the byte repeated MSB first at any starting bit
	function automatic logic shows_rotation(input logic [15:0] window, input logic [7:0] pattern);
		logic [23:0] stream;
		logic found;
		stream = {3{pattern}};
		found = 1'b0;
		for (int r = 0; r < 8; r++) begin
			if (window == stream[23-r -: 16]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		if (error_count == errors_at_start) begin
			$display("test %s: passed", test_name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
			tests_failed++;
		end
	endtask

	initial begin
		reset1 = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		ssel = 1'b1;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(32'h1e1c4f7d));
		repeat (2) @(negedge clock50);
		reset1 = 1'b0;
		repeat (4) @(negedge clock50);

		begin_test("write_read");
		// distinct word addresses so no write overwrites another
		for (int n = 0; n < 8; n++) begin
			addr_list[n] = {7'($urandom), 3'(n), 6'($urandom)};
			data_list[n] = $urandom;
			full_frame(opcode_write, addr_list[n], data_list[n], readback);
		end
		for (int n = 0; n < 8; n++) begin
			full_frame(opcode_read, addr_list[n], $urandom, readback);
			check_word(data_list[n], readback);
		end
		end_test();

		// upper address bits are dropped by the memory
		begin_test("aliasing");
		for (int n = 0; n < 4; n++) begin
			addr = {7'(n + 1), 9'($urandom)};
			wdata = $urandom;
			full_frame(opcode_write, addr, wdata, readback);
			full_frame(opcode_read, {7'h00, addr[8:0]}, $urandom, readback);
			check_word(wdata, readback);
		end
		end_test();

		begin_test("ignored_commands");
		addr = 16'h0123;
		wdata = $urandom;
		full_frame(opcode_write, addr, wdata, readback);
		leds_before = leds;
		full_frame(opcode_read, addr, ~wdata, readback);
		check_word(wdata, readback);
		full_frame(8'h5a, addr, ~wdata, readback);
		check_word(wdata, readback);
		check_word({24'h0, leds_before}, {24'h0, leds});
		full_frame(opcode_read, addr, $urandom, readback);
		check_word(wdata, readback);
		end_test();

		begin_test("led_byte");
		for (int n = 0; n < 4; n++) begin
			addr = 16'($urandom);
			wdata = $urandom;
			full_frame(opcode_write, addr, wdata, readback);
			check_word({24'h0, wdata[7:0]}, {24'h0, leds});
		end
		end_test();

		begin_test("short_frame");
		addr = 16'h01f0;
		wdata = $urandom;
		full_frame(opcode_write, addr, wdata, readback);
		leds_before = leds;
		send_frame(opcode_write, addr, ~wdata, 40, readback, short_seen);
		assert (!short_seen) else begin
			$display("%s: a 40-bit frame produced a transaction strobe", test_name);
			error_count++;
		end
		check_word({24'h0, leds_before}, {24'h0, leds});
		full_frame(opcode_read, addr, $urandom, readback);
		check_word(wdata, readback);
		end_test();

		// address stays on the last frame's value, so lemo repeats its low byte
		begin_test("serial_output");
		addr = 16'($urandom);
		wdata = {24'($urandom), 8'hb2};
		full_frame(opcode_write, addr, wdata, readback);
		full_frame(opcode_read, addr, $urandom, readback);
		samples = '0;
		for (int k = 0; k < 16; k++) begin
			@(negedge clock50);
			samples = {samples[14:0], lemo};
		end
		assert (shows_rotation(samples, wdata[7:0])) else begin
			$display("[ERROR] %s: expected %h repeated, actual %h", test_name, wdata[7:0], samples);
			error_count++;
		end
		end_test();

		$display("summary: %0d passed, %0d failed, %0d concurrent assertion failures",
			tests_passed, tests_failed, UUT.sva_checks.failure_count);
		if (tests_failed == 0 && UUT.sva_checks.failure_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: spi_pollable_memory.f
rtl/spi_memory_pkg.sv
rtl/word_memory.sv
rtl/word_serializer.sv
rtl/spi_frame_receiver.sv
rtl/memory_access_control.sv
rtl/spi_pollable_memory.sv
testbench/spi_pollable_memory_sva.sv
testbench/tb_spi_pollable_memory.sv
